// File: fp_alu_input.txt
# op a b expected_result expected_flags, all hex except flags
# op 0 add, 1 sub, 2 mul, 3 reserved; flags are invalid overflow underflow
0 3F800000 40000000 40400000 000
0 3FC00000 3FC00000 40400000 000
1 40400000 3F800000 40000000 000
1 3F800000 3F400000 3E800000 000
1 40000000 40000000 00000000 000
0 C0400000 3F800000 C0000000 000
2 3FC00000 40000000 40400000 000
2 C0000000 40400000 C0C00000 000
2 3FC00000 3FC00000 40100000 000
0 7FC00000 3F800000 7FC00000 100
1 3F800000 7F800001 7FC00000 100
2 FFC00000 40000000 7FC00000 100
1 7F800000 7F800000 7FC00000 100
2 00000000 7F800000 7FC00000 100
0 7F800000 3F800000 7F800000 000
0 00000000 40400000 40400000 000
1 00000000 40400000 C0400000 000
0 00000001 3F800000 3F800000 000
2 00400000 40000000 00000000 000
2 7F000000 40800000 7F800000 010
2 0D800000 0D800000 00000000 001
0 7F7FFFFF 7F7FFFFF 7F800000 010
3 3F800000 40000000 7FC00000 100
3 00000000 00000000 7FC00000 100

// File: fp_alu.f
fp_pkg.sv
fp_unpack.sv
fp_add_sub.sv
fp_mul.sv
fp_alu.sv
tb_fp_alu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_fp_alu
FILELIST  = fp_alu.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_fp_alu.sv
/*
 * Self-checking testbench for fp_alu, run from the project root.
 * Vectors are read from fp_alu_input.txt. The run stops at the first mismatch.
 */
`default_nettype none

module tb_fp_alu
    import fp_pkg::*;
();

    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 20;   // Cycles allowed for valid_out

    logic      clk;
    logic      rst;
    logic      start;
    fp_word_t  op_a;
    fp_word_t  op_b;
    fp_op_t    op_code;
    fp_word_t  result;
    fp_flags_t flags;
    logic      valid_out;

    logic [1:0] vec_op    [MAX_VEC];
    fp_word_t   vec_a     [MAX_VEC];
    fp_word_t   vec_b     [MAX_VEC];
    fp_word_t   vec_res   [MAX_VEC];
    fp_flags_t  vec_flags [MAX_VEC];
    int         num_vec;

    fp_alu i_fp_alu (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_code   (op_code),
        .result    (result),
        .flags     (flags),
        .valid_out (valid_out)
    );

    always #5 clk = ~clk;

    // ==============================
    // Helpers
    // ==============================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time=%0t signal=%s expected=0x%h actual=0x%h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic read_vectors();
        int         fd;
        int         n;
        string      line;
        logic [1:0] op;
        fp_word_t   a;
        fp_word_t   b;
        fp_word_t   res;
        logic [2:0] fl;
        fd = $fopen("fp_alu_input.txt", "r");
        if (fd == 0)
            stop_run("Could not open the vector file fp_alu_input.txt");
        num_vec = 0;
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;   // Blank or column header
            n = $sscanf(line, "%h %h %h %h %b", op, a, b, res, fl);
            if (n != 5)
                stop_run({"Malformed vector line: ", line});
            vec_op[num_vec]    = op;
            vec_a[num_vec]     = a;
            vec_b[num_vec]     = b;
            vec_res[num_vec]   = res;
            vec_flags[num_vec] = fl;
            num_vec++;
        end
        $fclose(fd);
        if (num_vec == 0)
            stop_run("The vector file holds no vectors");
    endtask

    // Counts falling edges until valid_out shows up
    task automatic wait_valid(output int cycles);
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (valid_out)
                seen = 1'b1;
            else if (cycles >= TIMEOUT)
                stop_run("valid_out never arrived after start");
        end
    endtask

    task automatic run_vector(input int idx);
        int lat;
        @(posedge clk);
        start   <= 1'b1;
        op_a    <= vec_a[idx];
        op_b    <= vec_b[idx];
        op_code <= fp_op_t'(vec_op[idx]);
        @(posedge clk);
        start <= 1'b0;
        wait_valid(lat);
        check_value("latency", 32'd2, 32'(lat));   // Second edge after start edge
        check_value("result", vec_res[idx], result);
        check_value("flags", 32'(vec_flags[idx]), 32'(flags));
        @(negedge clk);
        check_value("valid_out", 32'd0, 32'(valid_out));
        check_value("result", vec_res[idx], result);   // Held after the pulse
    endtask

    // start held into COMPUTE, with a new operand that must be ignored
    task automatic busy_start_check(input int idx);
        int pulses;
        @(posedge clk);
        start   <= 1'b1;
        op_a    <= vec_a[idx];
        op_b    <= vec_b[idx];
        op_code <= fp_op_t'(vec_op[idx]);
        @(posedge clk);
        op_a <= 32'hFFFF_FFFF;
        @(posedge clk);
        start  <= 1'b0;
        pulses = 0;
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            if (valid_out)
                pulses++;
        end
        check_value("valid_out pulses", 32'd1, 32'(pulses));
        check_value("result", vec_res[idx], result);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        start   = 1'b0;
        op_a    = '0;
        op_b    = '0;
        op_code = OP_ADD;
        read_vectors();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("result", 32'd0, result);
        check_value("flags", 32'd0, 32'(flags));
        check_value("valid_out", 32'd0, 32'(valid_out));
        for (int i = 0; i < num_vec; i++)
            run_vector(i);
        busy_start_check(0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: fp_alu.sv
/*
 * Binary32 add, subtract and multiply with a start/valid strobe.
 * Operands are latched on start, and valid_out pulses two edges later.
 * start is ignored while busy. There is no back-pressure.
 */
`default_nettype none

module fp_alu
    import fp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  fp_word_t  op_a,
    input  fp_word_t  op_b,
    input  fp_op_t    op_code,
    output fp_word_t  result,
    output fp_flags_t flags,
    output logic      valid_out
);

    typedef enum logic {
        IDLE,
        COMPUTE
    } state_t;

    state_t    state;
    fp_word_t  lat_a;
    fp_word_t  lat_b;
    fp_op_t    lat_op;
    fp_class_t cls_a;
    fp_class_t cls_b;
    fp_word_t  add_result;
    fp_flags_t add_flags;
    fp_word_t  mul_result;
    fp_flags_t mul_flags;
    fp_word_t  sel_result;
    fp_flags_t sel_flags;

    fp_unpack i_unpack_a (.word(lat_a), .cls(cls_a));
    fp_unpack i_unpack_b (.word(lat_b), .cls(cls_b));

    fp_add_sub i_add_sub (
        .a        (cls_a),
        .b        (cls_b),
        .subtract (lat_op == OP_SUB),
        .result   (add_result),
        .flags    (add_flags)
    );

    fp_mul i_mul (
        .a      (cls_a),
        .b      (cls_b),
        .result (mul_result),
        .flags  (mul_flags)
    );

    always_comb begin
        sel_result = QNAN;   // Reserved opcode
        sel_flags  = '{invalid: 1'b1, default: 1'b0};
        case (lat_op)
            OP_ADD, OP_SUB: begin
                sel_result = add_result;
                sel_flags  = add_flags;
            end
            OP_MUL: begin
                sel_result = mul_result;
                sel_flags  = mul_flags;
            end
            default: ;
        endcase
    end

    // ==============================
    // Controller and registers
    // ==============================
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            lat_a  <= op_a;
            lat_b  <= op_b;
            lat_op <= op_code;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            result    <= '0;
            flags     <= '0;
            valid_out <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    valid_out <= 1'b0;
                    if (start)
                        state <= COMPUTE;
                end
                COMPUTE: begin
                    result    <= sel_result;
                    flags     <= sel_flags;
                    valid_out <= 1'b1;
                    state     <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Single-cycle completion pulse
    a_valid_single: assert property (
        @(posedge clk) disable iff (rst) valid_out |=> !valid_out);

    a_valid_after_compute: assert property (
        @(posedge clk) disable iff (rst) (state == COMPUTE) |=> valid_out);

    a_valid_only_after_compute: assert property (
        @(posedge clk) disable iff (rst) valid_out |-> $past(state == COMPUTE));

endmodule

`default_nettype wire

// File: fp_mul.sv
/*
 * Combinational binary32 multiplier.
 * The product is truncated to 23 bits. There is no rounding.
 * Results below the normal range flush to signed zero.
 */
`default_nettype none

module fp_mul
    import fp_pkg::*;
(
    input  fp_class_t a,
    input  fp_class_t b,
    output fp_word_t  result,
    output fp_flags_t flags
);

    logic               sign_res;
    fp_sig_t            sig_a;
    fp_sig_t            sig_b;
    logic [47:0]        prod;
    logic signed [10:0] exp_wide;   // Room for both ends of the range
    fp_mant_t           mant_res;

    assign sign_res = a.sign ^ b.sign;
    assign sig_a    = {1'b1, a.mant};
    assign sig_b    = {1'b1, b.mant};

    // ==============================
    // Significand product and exponent
    // ==============================
    always_comb begin
        prod     = {24'b0, sig_a} * {24'b0, sig_b};
        exp_wide = 11'({3'b000, a.exp} + {3'b000, b.exp} - 11'(EXP_BIAS)
                       + {10'b0, prod[47]});
        if (prod[47])
            mant_res = prod[46:24];
        else
            mant_res = prod[45:23];
    end

    always_comb begin
        flags  = '0;
        result = '0;
        if (a.is_nan || b.is_nan) begin
            result        = QNAN;
            flags.invalid = 1'b1;
        end else if ((a.is_zero && b.is_inf) || (a.is_inf && b.is_zero)) begin
            result        = QNAN;
            flags.invalid = 1'b1;
        end else if (a.is_inf || b.is_inf) begin
            result = {sign_res, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
        end else if (a.is_zero || b.is_zero) begin
            result = {sign_res, {(WORD_W-1){1'b0}}};
        end else if (exp_wide >= 11'(EXP_MAX)) begin
            result         = {sign_res, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
            flags.overflow = 1'b1;
        end else if (exp_wide <= 11'sd0) begin
            result          = {sign_res, {(WORD_W-1){1'b0}}};
            flags.underflow = 1'b1;
        end else begin
            result = {sign_res, exp_wide[EXP_W-1:0], mant_res};
        end
    end

endmodule

`default_nettype wire

// File: fp_add_sub.sv
/*
 * Combinational binary32 adder and subtractor.
 * Surplus mantissa bits are truncated, there is no rounding.
 * An exact cancellation returns +0.
 */
`default_nettype none

module fp_add_sub
    import fp_pkg::*;
(
    input  fp_class_t a,
    input  fp_class_t b,
    input  logic      subtract,
    output fp_word_t  result,
    output fp_flags_t flags
);

    logic        sign_b_eff;
    fp_sig_t     sig_a;
    fp_sig_t     sig_b;
    fp_exp_t     exp_big;
    fp_exp_t     exp_diff;
    logic [47:0] al_a;
    logic [47:0] al_b;
    logic [48:0] sum;
    logic        sign_res;
    logic [5:0]  lz;
    logic [8:0]  exp_inc;
    logic [47:0] norm;

    // Position of the leading one counted from bit 47
    function automatic logic [5:0] lead_zeros(input logic [47:0] v);
        logic [5:0] n;
        n = 6'd48;
        for (int i = 0; i < 48; i++) begin
            if (v[i])
                n = 6'(47 - i);  // Highest set bit wins
        end
        return n;
    endfunction

    assign sign_b_eff = b.sign ^ subtract;
    assign sig_a      = {1'b1, a.mant};
    assign sig_b      = {1'b1, b.mant};

    // ==============================
    // Alignment and magnitude add
    // ==============================
    always_comb begin
        if (a.exp >= b.exp) begin
            exp_big  = a.exp;
            exp_diff = a.exp - b.exp;
            al_a     = {sig_a, 24'b0};
            al_b     = {sig_b, 24'b0} >> exp_diff;
        end else begin
            exp_big  = b.exp;
            exp_diff = b.exp - a.exp;
            al_a     = {sig_a, 24'b0} >> exp_diff;
            al_b     = {sig_b, 24'b0};
        end

        if (a.sign == sign_b_eff) begin
            sum      = {1'b0, al_a} + {1'b0, al_b};
            sign_res = a.sign;
        end else if (al_a >= al_b) begin
            sum      = {1'b0, al_a - al_b};
            sign_res = a.sign;
        end else begin
            sum      = {1'b0, al_b - al_a};
            sign_res = sign_b_eff;
        end

        lz      = lead_zeros(sum[47:0]);
        exp_inc = {1'b0, exp_big} + 9'd1;
        norm    = sum[47:0] << lz;
    end

    // ==============================
    // Special cases and normalization
    // ==============================
    always_comb begin
        flags  = '0;
        result = '0;
        if (a.is_nan || b.is_nan) begin
            result        = QNAN;
            flags.invalid = 1'b1;
        end else if (a.is_inf && b.is_inf && (a.sign != sign_b_eff)) begin
            result        = QNAN;  // Inf minus inf
            flags.invalid = 1'b1;
        end else if (a.is_inf) begin
            result = {a.sign, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
        end else if (b.is_inf) begin
            result = {sign_b_eff, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
        end else if (a.is_zero && b.is_zero) begin
            result = {a.sign & sign_b_eff, {(WORD_W-1){1'b0}}};
        end else if (a.is_zero) begin
            result = {sign_b_eff, b.exp, b.mant};
        end else if (b.is_zero) begin
            result = {a.sign, a.exp, a.mant};
        end else if (sum[48]) begin
            // Carry out, one step right
            if (exp_inc >= 9'(EXP_MAX)) begin
                result         = {sign_res, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
                flags.overflow = 1'b1;
            end else begin
                result = {sign_res, exp_inc[EXP_W-1:0], sum[47:25]};
            end
        end else if (sum[47]) begin
            result = {sign_res, exp_big, sum[46:24]};
        end else if (sum == '0) begin
            result = '0;
        end else if ({2'b00, lz} >= exp_big) begin
            result          = {sign_res, {(WORD_W-1){1'b0}}};
            flags.underflow = 1'b1;
        end else begin
            result = {sign_res, exp_big - {2'b00, lz}, norm[46:24]};
        end
    end

endmodule

`default_nettype wire

// File: fp_unpack.sv
/*
 * Splits a binary32 word into fields and classifies it.
 * A zero exponent flags zero regardless of the mantissa, so denormals flush.
 */
`default_nettype none

module fp_unpack
    import fp_pkg::*;
(
    input  fp_word_t  word,
    output fp_class_t cls
);

    logic     sign_f;
    fp_exp_t  exp_f;
    fp_mant_t mant_f;
    logic     exp_ones;
    logic     mant_nz;

    assign sign_f = word[WORD_W-1];
    assign exp_f  = word[WORD_W-2 -: EXP_W];
    assign mant_f = word[MANT_W-1:0];

    assign exp_ones = (exp_f == fp_exp_t'(EXP_MAX));
    assign mant_nz  = |mant_f;

    always_comb begin
        cls.sign    = sign_f;
        cls.exp     = exp_f;
        cls.mant    = mant_f;
        cls.is_nan  = exp_ones && mant_nz;
        cls.is_inf  = exp_ones && !mant_nz;
        cls.is_zero = (exp_f == '0);  // Denormal flush
    end

endmodule

`default_nettype wire

// File: fp_pkg.sv
/*
 * Shared types for the single-precision arithmetic unit.
 * Only IEEE-754 binary32 is supported. No rounding modes and no inexact flag.
 * Denormals are classified as zero by the unpacker.
 */
`default_nettype none

package fp_pkg;

    // ==============================
    // Format constants
    // ==============================
    localparam int EXP_W    = 8;
    localparam int MANT_W   = 23;
    localparam int WORD_W   = 1 + EXP_W + MANT_W;
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = (1 << EXP_W) - 1;  // All-ones exponent

    typedef logic [WORD_W-1:0] fp_word_t;
    typedef logic [EXP_W-1:0]  fp_exp_t;
    typedef logic [MANT_W-1:0] fp_mant_t;
    typedef logic [MANT_W:0]   fp_sig_t;   // Hidden bit on top

    // ==============================
    // Operand, flags, opcode
    // ==============================
    typedef struct packed {
        logic     sign;
        fp_exp_t  exp;
        fp_mant_t mant;
        logic     is_nan;
        logic     is_inf;
        logic     is_zero;   // Also set for denormals
    } fp_class_t;

    // Bit order invalid, overflow, underflow
    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
    } fp_flags_t;

    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_MUL  = 2'd2,
        OP_RSVD = 2'd3
    } fp_op_t;

    // Quiet NaN returned for every invalid operation
    localparam fp_word_t QNAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(MANT_W-1){1'b0}}};

endpackage

`default_nettype wire
